// File: logic/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes in inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // operation chosen by decode
    typedef enum logic [4:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // multiplies
        ALU_MUL,
        ALU_MULH,
        ALU_MULHSU,
        ALU_MULHU,
        // conditional branches
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_BLTU,
        ALU_BGEU,
        // jal and jalr
        ALU_JUMP,
        ALU_NONE
    } alu_op_e;

    // funct7 codes
    localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// File: logic/ex_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// stage 1 to stage 2 handoff
interface ex_issue_if import ex_pkg::*; ();

    logic      valid;
    logic      ready;
    alu_op_e   op;
    word_t     op1;
    word_t     op2;
    word_t     jump_addr;
    reg_addr_t rd;
    logic      we;

    modport src (
        output valid,
        output op,
        output op1,
        output op2,
        output jump_addr,
        output rd,
        output we,
        input  ready
    );

    modport dst (
        input  valid,
        input  op,
        input  op1,
        input  op2,
        input  jump_addr,
        input  rd,
        input  we,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  wire alu_op_e op_i,
    input  wire word_t   op1_i,
    input  wire word_t   op2_i,
    output word_t        result_o,
    output logic         taken_o
);

    word_t      sum;
    word_t      diff;
    logic [4:0] shamt;
    word_t      sr_shift;
    word_t      sr_mask;
    word_t      sra_res;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       eq;

    assign sum  = op1_i + op2_i;
    assign diff = op1_i - op2_i;

    assign shamt    = op2_i[4:0];
    assign sr_shift = op1_i >> shamt;
    assign sr_mask  = {XLEN{1'b1}} >> shamt;
    // sign fill into the vacated upper bits
    assign sra_res  = sr_shift | ({XLEN{op1_i[XLEN-1]}} & ~sr_mask);

    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;
    assign eq          = (op1_i == op2_i);

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SRL:  result_o = sr_shift;
            ALU_SRA:  result_o = sra_res;
            // link address
            ALU_JUMP: result_o = sum;
            default:  result_o = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            ALU_BEQ:  taken_o = eq;
            ALU_BNE:  taken_o = !eq;
            ALU_BLT:  taken_o = lt_signed;
            ALU_BGE:  taken_o = !lt_signed;
            ALU_BLTU: taken_o = lt_unsigned;
            ALU_BGEU: taken_o = !lt_unsigned;
            ALU_JUMP: taken_o = 1'b1;
            default:  taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/ex_mul.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mul import ex_pkg::*; (
    input  wire alu_op_e op_i,
    input  wire word_t   op1_i,
    input  wire word_t   op2_i,
    output word_t        result_o
);

    word_t               op1_neg;
    word_t               op2_neg;
    word_t               mul_op1;
    word_t               mul_op2;
    logic                negate;
    logic [2*XLEN-1:0]   product;
    logic [2*XLEN-1:0]   product_fix;

    assign op1_neg = ~op1_i + 1'b1;
    assign op2_neg = ~op2_i + 1'b1;

    // magnitudes of the signed operands
    always_comb begin
        mul_op1 = op1_i;
        mul_op2 = op2_i;
        negate  = 1'b0;
        case (op_i)
            ALU_MULH: begin
                mul_op1 = op1_i[XLEN-1] ? op1_neg : op1_i;
                mul_op2 = op2_i[XLEN-1] ? op2_neg : op2_i;
                negate  = op1_i[XLEN-1] ^ op2_i[XLEN-1];
            end
            ALU_MULHSU: begin
                mul_op1 = op1_i[XLEN-1] ? op1_neg : op1_i;
                negate  = op1_i[XLEN-1];
            end
            default: begin
                negate  = 1'b0;
            end
        endcase
    end

    assign product     = mul_op1 * mul_op2;
    assign product_fix = negate ? (~product + 1'b1) : product;

    // low half only for mul
    assign result_o = (op_i == ALU_MUL) ? product_fix[XLEN-1:0]
                                        : product_fix[2*XLEN-1:XLEN];

endmodule

`default_nettype wire

// File: logic/ex_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ex_decode import ex_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              in_valid_i,
    output logic                   in_ready_o,
    input  wire logic [INST_W-1:0] inst_i,
    input  wire word_t             op1_i,
    input  wire word_t             op2_i,
    input  wire word_t             op1_jump_i,
    input  wire word_t             op2_jump_i,
    input  wire reg_addr_t         reg_waddr_i,
    input  wire logic              reg_we_i,
    ex_issue_if.src                issue
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_bit;
    logic       f7_std;
    alu_op_e    dec_op;
    logic       s1_valid;
    logic       accept;

    assign opcode  = opcode_e'(inst_i[6:0]);
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign alt_bit = inst_i[30];

    // base or alternate funct7 where bit 30 picks sub / sra
    assign f7_std = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);

    always_comb begin
        dec_op = ALU_NONE;
        case (opcode)
            OP_IMM: begin
                case (funct3)
                    3'b000: dec_op = ALU_ADD;
                    3'b010: dec_op = ALU_SLT;
                    3'b011: dec_op = ALU_SLTU;
                    3'b100: dec_op = ALU_XOR;
                    3'b110: dec_op = ALU_OR;
                    3'b111: dec_op = ALU_AND;
                    3'b001: dec_op = (funct7 == FUNCT7_BASE) ? ALU_SLL : ALU_NONE;
                    default: dec_op = f7_std ? (alt_bit ? ALU_SRA : ALU_SRL) : ALU_NONE;
                endcase
            end
            OP_REG: begin
                if (funct7 == FUNCT7_MULDIV) begin
                    case (funct3)
                        3'b000: dec_op = ALU_MUL;
                        3'b001: dec_op = ALU_MULH;
                        3'b010: dec_op = ALU_MULHSU;
                        3'b011: dec_op = ALU_MULHU;
                        // divide and remainder not handled here
                        default: dec_op = ALU_NONE;
                    endcase
                end else if (f7_std) begin
                    case (funct3)
                        3'b000: dec_op = alt_bit ? ALU_SUB : ALU_ADD;
                        3'b101: dec_op = alt_bit ? ALU_SRA : ALU_SRL;
                        default: begin
                            if (!alt_bit) begin
                                case (funct3)
                                    3'b001: dec_op = ALU_SLL;
                                    3'b010: dec_op = ALU_SLT;
                                    3'b011: dec_op = ALU_SLTU;
                                    3'b100: dec_op = ALU_XOR;
                                    3'b110: dec_op = ALU_OR;
                                    default: dec_op = ALU_AND;
                                endcase
                            end
                        end
                    endcase
                end
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000: dec_op = ALU_BEQ;
                    3'b001: dec_op = ALU_BNE;
                    3'b100: dec_op = ALU_BLT;
                    3'b101: dec_op = ALU_BGE;
                    3'b110: dec_op = ALU_BLTU;
                    3'b111: dec_op = ALU_BGEU;
                    default: dec_op = ALU_NONE;
                endcase
            end
            OP_JAL: dec_op = ALU_JUMP;
            OP_JALR: dec_op = (funct3 == 3'b000) ? ALU_JUMP : ALU_NONE;
            // upper immediates are op1 + op2
            OP_LUI, OP_AUIPC: dec_op = ALU_ADD;
            default: dec_op = ALU_NONE;
        endcase
    end

    // stage is free when empty or draining this cycle
    assign in_ready_o = !s1_valid || issue.ready;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else if (accept) begin
            s1_valid <= 1'b1;
        end else if (issue.ready) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue.op        <= dec_op;
            issue.op1       <= op1_i;
            issue.op2       <= op2_i;
            issue.rd        <= reg_waddr_i;
            issue.we        <= reg_we_i;
            issue.jump_addr <= op1_jump_i + op2_jump_i;
        end
    end

    assign issue.valid = s1_valid;

endmodule

`default_nettype wire

// File: logic/ex_result.sv
`timescale 1ns/1ps
`default_nettype none

module ex_result import ex_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n_i,
    ex_issue_if.dst        issue,
    output logic           out_valid_o,
    input  wire logic      out_ready_i,
    output logic           reg_we_o,
    output reg_addr_t      reg_waddr_o,
    output word_t          reg_wdata_o,
    output logic           jump_flag_o,
    output word_t          jump_addr_o
);

    word_t alu_res;
    word_t mul_res;
    logic  taken;
    logic  is_mul;
    word_t wdata;
    word_t target;
    logic  accept;

    ex_alu u_alu (
        .op_i     (issue.op),
        .op1_i    (issue.op1),
        .op2_i    (issue.op2),
        .result_o (alu_res),
        .taken_o  (taken)
    );

    ex_mul u_mul (
        .op_i     (issue.op),
        .op1_i    (issue.op1),
        .op2_i    (issue.op2),
        .result_o (mul_res)
    );

    assign is_mul = (issue.op == ALU_MUL) || (issue.op == ALU_MULH) ||
                    (issue.op == ALU_MULHSU) || (issue.op == ALU_MULHU);
    assign wdata  = is_mul ? mul_res : alu_res;
    // not-taken branches report address 0
    assign target = taken ? issue.jump_addr : '0;

    assign issue.ready = !out_valid_o || out_ready_i;
    assign accept      = issue.valid && issue.ready;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            reg_we_o    <= 1'b0;
            jump_flag_o <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
            reg_we_o    <= issue.we;
            jump_flag_o <= taken;
        end else if (out_ready_i) begin
            // drained with nothing behind it
            out_valid_o <= 1'b0;
            reg_we_o    <= 1'b0;
            jump_flag_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_waddr_o <= issue.rd;
            reg_wdata_o <= wdata;
            jump_addr_o <= target;
        end
    end

endmodule

`default_nettype wire

// File: logic/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top import ex_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n_i,

    input  wire logic              in_valid_i,
    output logic                   in_ready_o,
    input  wire logic [INST_W-1:0] inst_i,
    input  wire word_t             op1_i,
    input  wire word_t             op2_i,
    input  wire word_t             op1_jump_i,
    input  wire word_t             op2_jump_i,
    input  wire reg_addr_t         reg_waddr_i,
    input  wire logic              reg_we_i,

    output logic                   out_valid_o,
    input  wire logic              out_ready_i,
    output logic                   reg_we_o,
    output reg_addr_t              reg_waddr_o,
    output word_t                  reg_wdata_o,
    output logic                   jump_flag_o,
    output word_t                  jump_addr_o
);

    ex_issue_if issue_if ();

    // stage 1
    ex_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .inst_i      (inst_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .op1_jump_i  (op1_jump_i),
        .op2_jump_i  (op2_jump_i),
        .reg_waddr_i (reg_waddr_i),
        .reg_we_i    (reg_we_i),
        .issue       (issue_if.src)
    );

    // stage 2
    ex_result u_result (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .issue       (issue_if.dst),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

endmodule

`default_nettype wire

// File: dv/tb_ex_ref.svh
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// 32-bit xorshift step with shifts 13 / 17 / 5
function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// expected {jump flag, jump address, write data} for one instruction
function automatic logic [64:0] ex_ref(input logic [31:0] inst, a, b, ja, jb);
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        prod;
    logic [31:0]        res;
    logic               tk;
    logic               alt;
    logic               ok;
    f3   = inst[14:12];
    f7   = inst[31:25];
    sa   = a;
    sb   = b;
    res  = '0;
    tk   = 1'b0;
    prod = 64'd0;
    // bit 30 selects sub or sra in register form but only sra in immediate form
    alt = inst[30] && (inst[5] || f3 == 3'b101);
    ok  = inst[5] ? (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)))
                  : (f3 == 3'b001 ? f7 == 7'h00
                                  : (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20));
    case (inst[6:0])
        7'b0010011, 7'b0110011: begin
            if (inst[5] && f7 == 7'h01) begin
                // sign-extended 64-bit products in modular arithmetic
                case (f3)
                    3'b000, 3'b011: prod = {32'd0, a} * {32'd0, b};
                    3'b001:         prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
                    3'b010:         prod = {{32{a[31]}}, a} * {32'd0, b};
                    default:        prod = 64'd0;
                endcase
                res = (f3 == 3'b000) ? prod[31:0] : prod[63:32];
            end else if (ok) begin
                case (f3)
                    3'b000: res = alt ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = {31'd0, sa < sb};
                    3'b011: res = {31'd0, a < b};
                    3'b100: res = a ^ b;
                    3'b101: begin
                        if (alt)
                            res = sa >>> b[4:0];
                        else
                            res = a >> b[4:0];
                    end
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
            end
        end
        7'b1100011: begin
            case (f3)
                3'b000:  tk = (a == b);
                3'b001:  tk = (a != b);
                3'b100:  tk = (sa < sb);
                3'b101:  tk = (sa >= sb);
                3'b110:  tk = (a < b);
                3'b111:  tk = (a >= b);
                default: tk = 1'b0;
            endcase
        end
        7'b1101111: begin
            tk  = 1'b1;
            res = a + b;
        end
        7'b1100111: begin
            tk  = (f3 == 3'b000);
            res = tk ? a + b : 32'd0;
        end
        7'b0110111, 7'b0010111: res = a + b;
        default: res = '0;
    endcase
    return {tk, tk ? ja + jb : 32'd0, res};
endfunction

`endif

// File: dv/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top import ex_pkg::*; ();

    localparam int SEED    = 48130;
    localparam int PERIOD  = 100;
    localparam int N_INT   = 200;
    localparam int N_SHIFT = 60;
    localparam int N_MUL   = 144;
    localparam int N_BR    = 58;
    localparam int N_STALL = 200;
    localparam int N_LAT   = 20;
    localparam int TOTAL   = N_INT + N_SHIFT + N_MUL + N_BR + N_STALL + N_LAT;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [INST_W-1:0] inst_i;
    word_t             op1_i;
    word_t             op2_i;
    word_t             op1_jump_i;
    word_t             op2_jump_i;
    reg_addr_t         reg_waddr_i;
    logic              reg_we_i;
    logic              out_valid_o;
    logic              out_ready_i = 1'b1;
    logic              reg_we_o;
    reg_addr_t         reg_waddr_o;
    word_t             reg_wdata_o;
    logic              jump_flag_o;
    word_t             jump_addr_o;

    logic [31:0] rng;
    logic [31:0] rdy_rng = SEED;
    logic [70:0] exp_q[$];
    int          acc_q[$];
    logic [70:0] snap;
    logic [70:0] exp_item;
    int          cyc = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          sent = 0;
    int          received = 0;
    logic        stall_mode = 1'b0;
    logic        gap_mode = 1'b0;
    logic        lat_check = 1'b0;
    logic        stalled = 1'b0;

    word_t corner [4] = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000};
    // equal, lt both, gt both, signed lt / unsigned gt and the reverse
    word_t br_a [8] = '{32'h1234_5678, 32'd3, 32'd7, 32'hffff_fffb,
                        32'd3, 32'h8000_0000, 32'h7fff_ffff, 32'd0};
    word_t br_b [8] = '{32'h1234_5678, 32'd7, 32'd3, 32'd3,
                        32'hffff_fffb, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};

    `include "tb_ex_ref.svh"

    ex_top uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    always @(posedge clk) begin
        rdy_rng = next_rand(rdy_rng);
        out_ready_i <= stall_mode ? rdy_rng[4] : 1'b1;
    end

    function automatic word_t rand32();
        rng = next_rand(rng);
        return rng;
    endfunction

    // rd and rs fields are random as they carry no meaning here
    function automatic word_t make_inst(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [6:0] opc);
        word_t f;
        f = rand32();
        return {f7, f[9:0], f3, f[14:10], opc};
    endfunction

    task automatic log_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        assert (got === exp)
            else log_error($sformatf("%s is %h, expected %h", name, got, exp));
    endtask

    task automatic send(input word_t inst, input word_t a, input word_t b);
        word_t       r;
        word_t       ja;
        word_t       jb;
        logic [64:0] ref_out;
        r  = rand32();
        ja = rand32();
        jb = rand32();
        if (gap_mode && r[1:0] == 2'b00) begin
            repeat (1 + r[2]) begin
                @(posedge clk);
                in_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid_i  <= 1'b1;
        inst_i      <= inst;
        op1_i       <= a;
        op2_i       <= b;
        op1_jump_i  <= ja;
        op2_jump_i  <= jb;
        reg_waddr_i <= r[12:8];
        reg_we_i    <= r[13];
        // transfer on the next rising edge
        do @(negedge clk); while (!in_ready_o);
        ref_out = ex_ref(inst, a, b, ja, jb);
        exp_q.push_back({r[13], r[12:8], ref_out[31:0], ref_out[64], ref_out[63:32]});
        acc_q.push_back(cyc);
        sent++;
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        in_valid_i <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        @(posedge clk);
        $display("test %s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // scoreboard sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (stalled) begin
                assert (out_valid_o && {reg_we_o, reg_waddr_o, reg_wdata_o, jump_flag_o,
                                        jump_addr_o} == snap)
                    else log_error("output changed while out_ready_i was low");
            end
            if (out_valid_o && !stalled && lat_check && acc_q.size() > 0) begin
                assert (cyc == acc_q[0] + 2)
                    else log_error($sformatf("latency %0d cycles, expected 2", cyc - acc_q[0]));
            end
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result: output accepted with nothing outstanding at %0t",
                             $time);
                    errors++;
                end else begin
                    exp_item = exp_q.pop_front();
                    acc_q.delete(0);
                    check_field("reg_we_o", reg_we_o, exp_item[70]);
                    check_field("reg_waddr_o", reg_waddr_o, exp_item[69:65]);
                    check_field("reg_wdata_o", reg_wdata_o, exp_item[64:33]);
                    check_field("jump_flag_o", jump_flag_o, exp_item[32]);
                    check_field("jump_addr_o", jump_addr_o, exp_item[31:0]);
                    received++;
                end
            end
            stalled = out_valid_o && !out_ready_i;
            snap    = {reg_we_o, reg_waddr_o, reg_wdata_o, jump_flag_o, jump_addr_o};
        end
    end

    // four cycles per item covers gaps and stalls
    initial begin : watchdog
        #(PERIOD * (4 * TOTAL + 50));
        $display("timeout: the run did not finish within %0d clock cycles", 4 * TOTAL + 50);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        word_t      r;
        word_t      a;
        word_t      b;
        word_t      inst;
        logic [2:0] f3;
        int         k;
        rng         = SEED;
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        inst_i      = '0;
        op1_i       = '0;
        op2_i       = '0;
        op1_jump_i  = '0;
        op2_jump_i  = '0;
        reg_waddr_i = '0;
        reg_we_i    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (!out_valid_o && !reg_we_o && !jump_flag_o)
            else log_error("outputs not low after reset");
        finish_test("reset values");

        lat_check = 1'b1;
        for (int i = 0; i < N_INT; i++) begin
            r = rand32();
            k = r[7:4] % 9;
            case (k)
                0, 1:    f3 = 3'b000;
                2, 3, 4: f3 = k[2:0];
                default: f3 = k[2:0] + 3'd1;
            endcase
            if (k >= 7)
                inst = make_inst(r[31:25], r[14:12], (k == 7) ? OP_LUI : OP_AUIPC);
            else if (k == 1 || r[0])
                inst = make_inst((k == 1) ? FUNCT7_ALT : FUNCT7_BASE, f3, OP_REG);
            else
                inst = make_inst(r[31:25], f3, OP_IMM);
            send(inst, rand32(), rand32());
        end
        finish_test("integer ops");

        for (int i = 0; i < N_SHIFT; i++) begin
            r = rand32();
            a = rand32();
            k = (i / 3) % 3;
            b = {r[31:5], (i % 3 == 0) ? 5'd0 : (i % 3 == 1) ? 5'd31 : r[4:0]};
            if (k == 2 && r[5])
                a[31] = 1'b1;
            f3 = (k == 0) ? 3'b001 : 3'b101;
            inst = make_inst((k == 2) ? FUNCT7_ALT : FUNCT7_BASE, f3, r[6] ? OP_REG : OP_IMM);
            send(inst, a, b);
        end
        finish_test("shifts");

        for (int i = 0; i < N_MUL; i++) begin
            inst = make_inst(FUNCT7_MULDIV, i[1:0], OP_REG);
            if (i < 80)
                send(inst, rand32(), rand32());
            else
                send(inst, corner[(i / 4) % 4], corner[(i / 16) % 4]);
        end
        finish_test("multiplies");

        for (int i = 0; i < 48; i++) begin
            r = rand32();
            k = i % 6;
            f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
            send(make_inst(r[31:25], f3, OP_BRANCH), br_a[i / 6], br_b[i / 6]);
        end
        for (int i = 0; i < N_BR - 48; i++) begin
            r = rand32();
            inst = make_inst(r[31:25], (i < 5) ? r[14:12] : 3'b000, (i < 5) ? OP_JAL : OP_JALR);
            send(inst, rand32(), rand32());
        end
        finish_test("branches");

        stall_mode = 1'b1;
        gap_mode   = 1'b1;
        lat_check  = 1'b0;
        for (int i = 0; i < N_STALL; i++) begin
            r = rand32();
            if (r[3])
                inst = make_inst(r[8] ? FUNCT7_MULDIV : FUNCT7_BASE, r[14:12], OP_REG);
            else
                inst = make_inst(r[31:25], r[14:12], OP_BRANCH);
            send(inst, rand32(), rand32());
        end
        finish_test("back-pressure");
        stall_mode = 1'b0;
        gap_mode   = 1'b0;

        @(posedge clk);
        lat_check = 1'b1;
        for (int i = 0; i < N_LAT; i++)
            send(make_inst(FUNCT7_BASE, 3'b000, OP_REG), rand32(), rand32());
        finish_test("latency");

        repeat (4) @(negedge clk);
        if (received != sent)
            $display("result count mismatch: %0d sent, %0d received", sent, received);
        $display("%0d instructions, %0d results, %0d errors", sent, received, errors);
        if (errors == 0 && received == sent) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+dv
logic/ex_pkg.sv
logic/ex_issue_if.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_decode.sv
logic/ex_result.sv
logic/ex_top.sv
dv/tb_ex_top.sv
